// File: Bender.yml
package:
  name: calculator

sources:
  - include_dirs:
      - logic
    files:
      - logic/calc_pkg.sv
      - logic/keyEntry.sv
      - logic/exprEvaluator.sv
      - logic/resultFormatter.sv
      - logic/calculatorTop.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/clockGen.sv
      - tests/calc_asserts.sv
      - tests/calculatorTb.sv

// File: flist.f
+incdir+logic
logic/calc_pkg.sv
logic/keyEntry.sv
logic/exprEvaluator.sv
logic/resultFormatter.sv
logic/calculatorTop.sv
tests/clockGen.sv
tests/calc_asserts.sv
tests/calculatorTb.sv

// File: logic/calc_config.svh
`ifndef CALC_CONFIG_SVH
`define CALC_CONFIG_SVH

// datapath widths
`define CALC_WIDTH 24
`define KEY_WIDTH 4
`define DIGIT_COUNT_WIDTH 4

// two precedence levels never hold more than 3 numbers
`define STACK_DEPTH 4

// key codes, 0 to 9 are digits
`define KEY_PLUS 4'd10
`define KEY_MINUS 4'd11
`define KEY_EQUALS 4'd12
`define KEY_TIMES 4'd13
`define KEY_BACK 4'd14
`define KEY_DIVIDE 4'd15

`endif

// File: logic/calc_pkg.sv
`include "calc_config.svh"

package calc_pkg;

	// two's complement operand
	typedef logic signed [`CALC_WIDTH-1:0] operand_t;

	// absolute value of an operand
	typedef logic [`CALC_WIDTH-1:0] magnitude_t;

	typedef logic [`KEY_WIDTH-1:0] keyCode_t;

	typedef logic [`DIGIT_COUNT_WIDTH-1:0] digitCount_t;

	typedef enum logic [1:0] {
		IDLE,
		FORWARD, // token out, waiting for tokAck
		ACKED
	} entryState_t;

	typedef enum logic [2:0] {
		WAIT,
		REDUCE,
		PUSH,
		FLUSH, // equals, reduce everything
		EMIT,
		DONE
	} evalState_t;

endpackage

// File: logic/calculatorTop.sv
`timescale 1ns/1ps

module calculatorTop import calc_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        keyReq,
	input  keyCode_t    keyCode,
	output logic        keyAck,
	output logic        resReq,
	input  logic        resAck,
	output logic        resSign,
	output magnitude_t  resMagnitude,
	output digitCount_t resDigits,
	output logic        resError
);

	// key entry to evaluator
	logic tokReq;
	logic tokAck;
	keyCode_t tokKey;
	operand_t tokOperand;

	// evaluator to formatter
	logic valReq;
	logic valAck;
	operand_t valResult;
	logic valError;

	keyEntry entryU (
		.clk(clk),
		.rst_n(rst_n),
		.keyReq(keyReq),
		.keyCode(keyCode),
		.tokAck(tokAck),
		.keyAck(keyAck),
		.tokReq(tokReq),
		.tokKey(tokKey),
		.tokOperand(tokOperand)
	);

	exprEvaluator evalU (
		.clk(clk),
		.rst_n(rst_n),
		.tokReq(tokReq),
		.tokKey(tokKey),
		.tokOperand(tokOperand),
		.valAck(valAck),
		.tokAck(tokAck),
		.valReq(valReq),
		.valResult(valResult),
		.valError(valError)
	);

	resultFormatter fmtU (
		.clk(clk),
		.rst_n(rst_n),
		.valReq(valReq),
		.valResult(valResult),
		.valError(valError),
		.resAck(resAck),
		.valAck(valAck),
		.resReq(resReq),
		.resSign(resSign),
		.resMagnitude(resMagnitude),
		.resDigits(resDigits),
		.resError(resError)
	);

endmodule

// File: logic/exprEvaluator.sv
`timescale 1ns/1ps
`include "calc_config.svh"

module exprEvaluator import calc_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     tokReq,
	input  keyCode_t tokKey,
	input  operand_t tokOperand,
	input  logic     valAck,
	output logic     tokAck,
	output logic     valReq,
	output operand_t valResult,
	output logic     valError
);

	localparam int IDX_W = $clog2(`STACK_DEPTH);
	localparam int CNT_W = $clog2(`STACK_DEPTH + 1);

	evalState_t state;
	operand_t numStack [`STACK_DEPTH];
	keyCode_t opStack [`STACK_DEPTH];
	logic [CNT_W-1:0] numCount;
	logic [CNT_W-1:0] opCount;
	logic [IDX_W-1:0] numTop;
	logic [IDX_W-1:0] numNext;
	logic [IDX_W-1:0] opTop;
	logic [IDX_W-1:0] opNext;
	operand_t lhs;
	operand_t rhs;
	operand_t aluResult;
	logic divByZero;
	logic needReduce;
	logic needNext;
	logic reduceNow;

	function automatic logic isHigh(keyCode_t k);
		return k == `KEY_TIMES || k == `KEY_DIVIDE;
	endfunction

	// indices wrap harmlessly when a stack is nearly empty
	assign numTop = IDX_W'(numCount - 1'b1);
	assign numNext = IDX_W'(numCount - 2'd2);
	assign opTop = IDX_W'(opCount - 1'b1);
	assign opNext = IDX_W'(opCount - 2'd2);

	assign lhs = numStack[numNext];
	assign rhs = numStack[numTop];

	// top operator binds at least as tight as the incoming one
	assign needReduce = opCount != '0 && (isHigh(opStack[opTop]) || !isHigh(tokKey));
	assign needNext = opCount > CNT_W'(1) && (isHigh(opStack[opNext]) || !isHigh(tokKey));

	assign reduceNow = state == REDUCE || (state == FLUSH && opCount != '0);

	always_comb begin
		aluResult = rhs;
		divByZero = 1'b0;
		case (opStack[opTop])
			`KEY_PLUS: aluResult = lhs + rhs;
			`KEY_MINUS: aluResult = lhs - rhs;
			`KEY_TIMES: aluResult = lhs * rhs; // low bits only
			`KEY_DIVIDE: begin
				if (rhs == '0) begin
					aluResult = '0;
					divByZero = 1'b1;
				end else
					aluResult = lhs / rhs; // truncates toward zero
			end
			default: aluResult = rhs;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= WAIT;
			numCount <= '0;
			opCount <= '0;
			tokAck <= 1'b0;
			valReq <= 1'b0;
			valError <= 1'b0;
		end else begin
			if (reduceNow) begin
				numCount <= numCount - 1'b1;
				opCount <= opCount - 1'b1;
				if (divByZero)
					valError <= 1'b1; // sticky until emitted
			end
			case (state)
				WAIT: begin
					if (tokReq) begin
						numCount <= numCount + 1'b1;
						if (tokKey == `KEY_EQUALS)
							state <= FLUSH;
						else if (needReduce)
							state <= REDUCE;
						else
							state <= PUSH;
					end
				end
				REDUCE: state <= needNext ? REDUCE : PUSH;
				PUSH: begin
					opCount <= opCount + 1'b1;
					tokAck <= 1'b1;
					state <= DONE;
				end
				FLUSH: begin
					if (opCount == '0 && !valAck) begin
						valReq <= 1'b1;
						state <= EMIT;
					end
				end
				EMIT: begin
					if (valAck) begin
						valReq <= 1'b0;
						numCount <= '0;
						opCount <= '0;
						valError <= 1'b0;
						tokAck <= 1'b1;
						state <= DONE;
					end
				end
				DONE: begin
					if (!tokReq) begin
						tokAck <= 1'b0;
						state <= WAIT;
					end
				end
				default: state <= WAIT;
			endcase
		end
	end

	// stack contents and result payload
	always_ff @(posedge clk) begin
		if (state == WAIT && tokReq)
			numStack[IDX_W'(numCount)] <= tokOperand;
		if (reduceNow)
			numStack[numNext] <= aluResult;
		if (state == PUSH)
			opStack[IDX_W'(opCount)] <= tokKey;
		if (state == FLUSH && opCount == '0)
			valResult <= numStack[0]; // single number left
	end

endmodule

// File: logic/keyEntry.sv
`timescale 1ns/1ps
`include "calc_config.svh"

module keyEntry import calc_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     keyReq,
	input  keyCode_t keyCode,
	input  logic     tokAck,
	output logic     keyAck,
	output logic     tokReq,
	output keyCode_t tokKey,
	output operand_t tokOperand
);

	localparam operand_t TEN = 10;

	entryState_t state;
	operand_t entry;
	logic isDigit;

	assign isDigit = keyCode < `KEY_PLUS; // codes below plus are digits

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			keyAck <= 1'b0;
			tokReq <= 1'b0;
			entry <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (keyReq) begin
						if (isDigit) begin
							entry <= entry * TEN + operand_t'(keyCode); // wraps
							state <= ACKED;
						end else if (keyCode == `KEY_BACK) begin
							entry <= entry / TEN;
							state <= ACKED;
						end else if (!tokAck) begin
							tokReq <= 1'b1;
							state <= FORWARD;
						end
					end
				end
				FORWARD: begin
					if (tokAck) begin
						tokReq <= 1'b0;
						entry <= '0; // next number starts fresh
						state <= ACKED;
					end
				end
				ACKED: begin
					if (!keyAck)
						keyAck <= 1'b1;
					else if (!keyReq) begin
						keyAck <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// token payload, stable until tokAck
	always_ff @(posedge clk) begin
		if (state == IDLE && keyReq) begin
			tokKey <= keyCode;
			tokOperand <= entry;
		end
	end

endmodule

// File: logic/resultFormatter.sv
`timescale 1ns/1ps
`include "calc_config.svh"

module resultFormatter import calc_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        valReq,
	input  operand_t    valResult,
	input  logic        valError,
	input  logic        resAck,
	output logic        valAck,
	output logic        resReq,
	output logic        resSign,
	output magnitude_t  resMagnitude,
	output digitCount_t resDigits,
	output logic        resError
);

	localparam int MAX_DIGITS = 8; // 2^24 - 1 has 8 digits

	logic slotFull;
	logic accept;
	magnitude_t absVal;

	// zero counts as one digit
	function automatic digitCount_t countDigits(magnitude_t m);
		digitCount_t n;
		longint unsigned limit;
		n = digitCount_t'(1);
		limit = 10;
		for (int i = 1; i < MAX_DIGITS; i++) begin
			if (m >= limit)
				n = n + 1'b1;
			limit = limit * 10;
		end
		return n;
	endfunction

	assign accept = valReq && !valAck && !slotFull;
	assign absVal = valResult[`CALC_WIDTH-1] ? magnitude_t'(-valResult) : magnitude_t'(valResult);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valAck <= 1'b0;
			resReq <= 1'b0;
			slotFull <= 1'b0;
		end else begin
			if (accept)
				valAck <= 1'b1;
			else if (!valReq)
				valAck <= 1'b0;

			if (accept) begin
				resReq <= 1'b1;
				slotFull <= 1'b1;
			end else if (resReq && resAck)
				resReq <= 1'b0;
			else if (slotFull && !resReq && !resAck)
				slotFull <= 1'b0; // free once resAck falls
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			resSign <= valResult[`CALC_WIDTH-1];
			resMagnitude <= absVal;
			resDigits <= countDigits(absVal);
			resError <= valError;
		end
	end

endmodule

// File: tests/calc_asserts.sv
`timescale 1ns/1ps

module calcAsserts (
	input logic clk,
	input logic rst_n,
	input logic keyReq,
	input logic keyAck,
	input logic resReq,
	input logic resAck
);

	int failures = 0;

	// ack only answers a pending request
	keyAckNeedsReq: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(keyAck) |-> keyReq)
		else begin
			$error("keyAck rose while keyReq was low");
			failures++;
		end

	resReqHeld: assert property (@(posedge clk) disable iff (!rst_n)
		(resReq && !resAck) |=> resReq)
		else begin
			$error("resReq dropped before resAck");
			failures++;
		end

	quietInReset: assert property (@(posedge clk)
		!rst_n |-> (!keyAck && !resReq))
		else begin
			$error("handshake outputs active during reset");
			failures++;
		end

endmodule

bind calculatorTop calcAsserts asserts (
	.clk(clk),
	.rst_n(rst_n),
	.keyReq(keyReq),
	.keyAck(keyAck),
	.resReq(resReq),
	.resAck(resAck)
);

// File: tests/calculatorTb.sv
`timescale 1ns/1ps
`include "calc_config.svh"

module calculatorTb import calc_pkg::*; ();

	localparam int NUM_RANDOM = 40;
	localparam int MAX_KEYS = 37 + NUM_RANDOM * 24; // fixed tests plus worst random
	localparam int CYCLES_PER_KEY = 200;

	logic clk;
	logic rst_n;
	logic keyReq;
	keyCode_t keyCode;
	logic keyAck;
	logic resReq;
	logic resAck;
	logic resSign;
	magnitude_t resMagnitude;
	digitCount_t resDigits;
	logic resError;

	operand_t expVals[$];
	bit expErrs[$];
	logic obsSign[$];
	magnitude_t obsMag[$];
	digitCount_t obsDigits[$];
	logic obsErr[$];

	clockGen clkU (.clk(clk), .rst_n(rst_n));

	calculatorTop DUT (
		.clk(clk),
		.rst_n(rst_n),
		.keyReq(keyReq),
		.keyCode(keyCode),
		.keyAck(keyAck),
		.resReq(resReq),
		.resAck(resAck),
		.resSign(resSign),
		.resMagnitude(resMagnitude),
		.resDigits(resDigits),
		.resError(resError)
	);

	task automatic reportFailure(string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic wrongValue(string msg);
		reportFailure($sformatf("[FAIL] %0t: %s", $time, msg));
	endtask

	// left to right, times and divide first
	function automatic operand_t evalExpr(input keyCode_t keys[$], output bit err);
		operand_t entry;
		operand_t nums[$];
		keyCode_t ops[$];
		operand_t acc;
		operand_t sum;
		keyCode_t lowOp;
		entry = 0;
		err = 0;
		foreach (keys[i]) begin
			if (keys[i] < 10)
				entry = entry * operand_t'(10) + operand_t'(keys[i]);
			else if (keys[i] == `KEY_BACK)
				entry = entry / operand_t'(10);
			else begin
				nums.push_back(entry);
				if (keys[i] != `KEY_EQUALS)
					ops.push_back(keys[i]);
				entry = 0;
			end
		end
		acc = nums[0];
		sum = 0;
		lowOp = `KEY_PLUS;
		foreach (ops[i]) begin
			if (ops[i] == `KEY_TIMES)
				acc = acc * nums[i+1];
			else if (ops[i] == `KEY_DIVIDE) begin
				if (nums[i+1] == 0) begin
					acc = 0;
					err = 1;
				end else
					acc = acc / nums[i+1];
			end else begin
				sum = (lowOp == `KEY_PLUS) ? sum + acc : sum - acc;
				lowOp = ops[i];
				acc = nums[i+1];
			end
		end
		sum = (lowOp == `KEY_PLUS) ? sum + acc : sum - acc;
		return sum;
	endfunction

	function automatic digitCount_t digitsOf(magnitude_t m);
		digitCount_t n;
		n = 1;
		while (m >= 10) begin
			m = m / 10;
			n++;
		end
		return n;
	endfunction

	task automatic checkOperand(operand_t expVal, logic gotSign, magnitude_t gotMag);
		magnitude_t expMag;
		expMag = (expVal < 0) ? magnitude_t'(-expVal) : magnitude_t'(expVal);
		if (gotSign !== (expVal < 0) || gotMag !== expMag)
			wrongValue($sformatf("result %0d, got sign %0b magnitude %0d",
				expVal, gotSign, gotMag));
	endtask

	task automatic checkDigits(digitCount_t expDigits, digitCount_t gotDigits);
		if (gotDigits !== expDigits)
			wrongValue($sformatf("digit count %0d, got %0d", expDigits, gotDigits));
	endtask

	task automatic checkError(bit expErr, logic gotErr);
		if (gotErr !== expErr)
			wrongValue($sformatf("error flag %0b, got %0b", expErr, gotErr));
	endtask

	task automatic pressKey(keyCode_t k);
		@(posedge clk);
		keyReq <= 1'b1;
		keyCode <= k;
		do @(negedge clk); while (!keyAck);
		@(posedge clk);
		keyReq <= 1'b0;
		do @(negedge clk); while (keyAck);
	endtask

	task automatic runKeys(keyCode_t keys[$]);
		bit err;
		operand_t v;
		v = evalExpr(keys, err);
		expVals.push_back(v);
		expErrs.push_back(err);
		foreach (keys[i])
			pressKey(keys[i]);
	endtask

	// '<' is backspace
	task automatic runText(string s);
		keyCode_t keys[$];
		for (int i = 0; i < s.len(); i++) begin
			case (s[i])
				"+": keys.push_back(`KEY_PLUS);
				"-": keys.push_back(`KEY_MINUS);
				"*": keys.push_back(`KEY_TIMES);
				"/": keys.push_back(`KEY_DIVIDE);
				"<": keys.push_back(`KEY_BACK);
				"=": keys.push_back(`KEY_EQUALS);
				default: keys.push_back(keyCode_t'(s[i] - "0"));
			endcase
		end
		runKeys(keys);
	endtask

	task automatic runRandom();
		keyCode_t keys[$];
		keyCode_t opSet[4] = '{`KEY_PLUS, `KEY_MINUS, `KEY_TIMES, `KEY_DIVIDE};
		int nOps;
		int nDigits;
		nOps = $urandom_range(0, 3);
		for (int o = 0; o <= nOps; o++) begin
			nDigits = $urandom_range(1, 4);
			for (int d = 0; d < nDigits; d++)
				keys.push_back(keyCode_t'($urandom_range(0, 9)));
			if ($urandom_range(0, 7) == 0)
				keys.push_back(`KEY_BACK);
			if (o < nOps)
				keys.push_back(opSet[$urandom_range(0, 3)]);
		end
		keys.push_back(`KEY_EQUALS);
		runKeys(keys);
	endtask

	// result side, random back-pressure
	initial begin
		resAck = 1'b0;
		forever begin
			@(negedge clk);
			if (resReq && !resAck) begin
				obsSign.push_back(resSign);
				obsMag.push_back(resMagnitude);
				obsDigits.push_back(resDigits);
				obsErr.push_back(resError);
				repeat ($urandom_range(0, 5)) @(posedge clk);
				@(posedge clk);
				resAck <= 1'b1;
				do @(negedge clk); while (resReq);
				@(posedge clk);
				resAck <= 1'b0;
			end
		end
	end

	// comparator
	initial begin
		operand_t v;
		magnitude_t expMag;
		forever begin
			@(negedge clk);
			if (obsSign.size() > 0) begin
				if (expVals.size() == 0)
					reportFailure("DUT produced a result that no expression asked for");
				else begin
					v = expVals.pop_front();
					expMag = (v < 0) ? magnitude_t'(-v) : magnitude_t'(v);
					checkOperand(v, obsSign.pop_front(), obsMag.pop_front());
					checkDigits(digitsOf(expMag), obsDigits.pop_front());
					checkError(expErrs.pop_front(), obsErr.pop_front());
				end
			end
		end
	end

	// bound handshake checks
	initial begin
		wait (DUT.asserts.failures != 0);
		reportFailure("a handshake assertion failed");
	end

	initial begin
		repeat (16 + MAX_KEYS * CYCLES_PER_KEY) @(posedge clk);
		reportFailure("timeout: the DUT stopped answering keys or results");
	end

	initial begin
		void'($urandom(18227));
		keyReq = 1'b0;
		keyCode = '0;
		@(posedge rst_n);
		runText("1234567=");
		runText("123<=");
		runText("2+3*4=");
		runText("8-6/2=");
		runText("7-9=");
		runText("5/0=");
		runText("9*9="); // flag must be clear again
		for (int i = 0; i < NUM_RANDOM; i++)
			runRandom();
		while (expVals.size() > 0 || obsSign.size() > 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		$display("No errors");
		$finish;
	end

endmodule

// File: tests/clockGen.sv
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic rst_n
);

	initial clk = 1'b0;
	always #2 clk = ~clk; // 4 ns period

	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule
